//--- common/csctl_pkg.sv
// Control-store control package with phase code, sizes, vector types and strobe structs
`default_nettype none

package csctl_pkg;

    // Field widths fixed by the microword format
    localparam int MA_WIDTH   = 8;                  // Micro address within one bank
    localparam int MW_WIDTH   = 32;                 // Microinstruction word
    localparam int CC_WIDTH   = 3;                  // Phase code cc3..cc1
    localparam int CIDX_WIDTH = 4;                  // Cache index from low address bits

    // Memory depths
    localparam int CS_DEPTH    = 1 << MA_WIDTH;     // Words per control store bank
    localparam int CACHE_DEPTH = 16;                // Microinstruction cache entries

    // Last phase of the microcycle, term_n low here
    localparam logic [CC_WIDTH-1:0] PHASE_LAST = 3'd7;

    typedef logic [MA_WIDTH-1:0]   micro_addr_t;    // Index within a bank
    typedef logic [MW_WIDTH-1:0]   micro_word_t;    // One microinstruction
    typedef logic [CIDX_WIDTH-1:0] cache_idx_t;     // Cache entry number

    // Phase code, active high
    // Bit 2 is cc3, bit 1 is cc2, bit 0 is cc1
    // Phase a is 0 and phase h is 7
    typedef logic [CC_WIDTH-1:0] cc_code_t;

    // Mode and fetch inputs to the strobe decode
    typedef struct packed {
        logic form_n;                               // Map format cycle
        logic lcs_n;                                // Load control store
        logic rwcs_n;                               // Read/write control store
        logic wcs_n;                                // Write control store
        logic brk_n;                                // Break in progress
        logic wca_n;                                // Write cache address
        logic fetch;                                // Instruction fetch, active high
        logic lua12;                                // Upper bank select, active high
    } csctl_ctl_t;

    // Strobes from the decode, all active low
    typedef struct packed {
        logic wica_n;                               // Write pulse into microinstruction cache
        logic wcstb_n;                              // Write pulse into writable store
        logic ecsl_n;                               // Hold the output latch
        logic ewca_n;                               // Put write-address register on ma
        logic eupp_n;                               // Enable upper bank read
        logic elow_n;                               // Enable lower bank read
    } csctl_strobe_t;

endpackage

`default_nettype wire

//--- verilog/cycle_timer.sv
// Microcycle timer, free-running eight-phase counter with term_n on the last phase
`timescale 1ns/100ps
`default_nettype none

module cycle_timer (
    input  wire                  clk,
    input  wire                  rst_n,
    output csctl_pkg::cc_code_t  cc,        // Current phase a..h
    output logic                 term_n     // Low in phase h only
);

    import csctl_pkg::*;

    cc_code_t phase_q;                      // Registered phase

    // Phase counter, wraps from h back to a
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase_q <= '0;                  // Start in phase a
        end else if (phase_q == PHASE_LAST) begin
            phase_q <= '0;
        end else begin
            phase_q <= phase_q + 3'd1;
        end
    end

    assign cc     = phase_q;
    assign term_n = (phase_q != PHASE_LAST); // Decoded from the register, glitch free

    // Terminate marks phase h and the cycle restarts in phase a
    a_term_wraps : assert property (
        @(posedge clk) disable iff (!rst_n)
        !term_n |-> (cc == PHASE_LAST) ##1 (cc == '0)
    ) else $error("term_n low outside phase h or no wrap to phase a");

endmodule

`default_nettype wire

//--- csctl/csctl_decode.sv
// Control-store strobe decode, sum-of-products equations for the six active-low strobes
`timescale 1ns/100ps
`default_nettype none

module csctl_decode (
    input  wire                       clk,      // Assertions only
    input  wire                       rst_n,    // Assertions only
    input  wire csctl_pkg::csctl_ctl_t ctl,     // Mode and fetch inputs
    input  wire csctl_pkg::cc_code_t  cc,       // Phase from the timer
    input  wire                       term_n,   // Last phase marker
    output csctl_pkg::csctl_strobe_t  strb      // Decoded strobes
);

    // Active-high copies of the mode inputs
    logic form, lcs, rwcs, wcs, brk, wca;
    logic cc1, cc2, cc3;
    logic term;

    assign form = ~ctl.form_n;
    assign lcs  = ~ctl.lcs_n;
    assign rwcs = ~ctl.rwcs_n;
    assign wcs  = ~ctl.wcs_n;
    assign brk  = ~ctl.brk_n;
    assign wca  = ~ctl.wca_n;
    assign cc1  = cc[0];
    assign cc2  = cc[1];
    assign cc3  = cc[2];
    assign term = ~term_n;

    // Cache write pulse on a fetch with wca, never in the last phase
    assign strb.wica_n = ~(wca & ctl.fetch & term_n);

    // Store write pulse, late in the cycle for slow PROM timing
    assign strb.wcstb_n = ~((~cc3 & cc2 & cc1 & wcs & rwcs)   // Phase 3 on a wcs write
                          | (cc3 & ~cc2 & cc1 & lcs));        // Phase 5 on load control

    // Output latch hold on a control store read
    assign strb.ecsl_n = ~((rwcs & ~wcs & cc3 & term_n)        // Phases 4 to 6
                         | (rwcs & ~wcs & ~cc1 & cc2 & term_n)); // Phase 2, overlaps ewca

    // Write-address register onto ma, kept off phase 0 to avoid a blip
    assign strb.ewca_n = ~((rwcs & ~cc3 & cc2 & term_n)
                         | (rwcs & ~cc3 & cc1 & term_n));

    // Upper bank read enable
    assign strb.eupp_n = ~(ctl.lua12                           // Normal addressing
                         | (wca & ctl.fetch)                   // Cache fill
                         | (ctl.fetch & ~cc1 & ~cc2 & ~cc3 & term_n)); // Early fetch window

    // Lower bank read enable
    assign strb.elow_n = ~((~ctl.lua12 & ~ctl.fetch)           // Normal addressing
                         | (~ctl.lua12 & term)                 // Bank by lua12 before fetch
                         | (form & ~brk & cc2 & term_n)        // Map cycle
                         | (form & ~brk & cc3 & term_n)
                         | (~ctl.lua12 & brk & cc2 & term_n)   // Break uses lua12 bank
                         | (~ctl.lua12 & brk & cc3 & term_n));

    // No store write in the terminate phase of the timer
    a_wcstb_not_term : assert property (
        @(posedge clk) disable iff (!rst_n) !term_n |-> strb.wcstb_n
    ) else $error("wcstb_n low while term_n low");

    // ewca only inside phases 1 to 3
    a_ewca_window : assert property (
        @(posedge clk) disable iff (!rst_n) !strb.ewca_n |-> (cc inside {3'd1, 3'd2, 3'd3})
    ) else $error("ewca_n low outside phases 1 to 3");

    // Cache writes belong to fetch cycles
    a_wica_fetch : assert property (
        @(posedge clk) disable iff (!rst_n) !strb.wica_n |-> ctl.fetch
    ) else $error("wica_n low without fetch");

endmodule

`default_nettype wire

//--- control_store/control_store.sv
// Writable control store, upper and lower microcode banks with output hold latch
`timescale 1ns/100ps
`default_nettype none

module control_store (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire csctl_pkg::micro_addr_t  ma,      // Effective micro address
    input  wire                          lua12,   // Write bank select, high is upper
    input  wire csctl_pkg::micro_word_t  wdata,   // Microword to write
    input  wire csctl_pkg::csctl_strobe_t strb,   // Strobes from the decode
    output csctl_pkg::micro_word_t       cs_data  // Latched microword
);

    import csctl_pkg::*;

    // Two banks of microcode
    micro_word_t upp_mem [CS_DEPTH];
    micro_word_t low_mem [CS_DEPTH];

    micro_word_t rd_word;                   // Bank output before the latch
    logic        rd_en;                     // Some bank is enabled

    // Write on the store strobe into the bank chosen by lua12
    always_ff @(posedge clk) begin
        if (!strb.wcstb_n) begin
            if (lua12) begin
                upp_mem[ma] <= wdata;
            end else begin
                low_mem[ma] <= wdata;
            end
        end
    end

    // Bank select, upper has priority over lower
    always_comb begin
        rd_en   = 1'b1;
        rd_word = upp_mem[ma];
        if (strb.eupp_n) begin
            rd_word = low_mem[ma];
            rd_en   = ~strb.elow_n;         // Neither enabled keeps the old word
        end
    end

    // Output latch
    // Loads the enabled bank each cycle, holds while ecsl_n is low
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cs_data <= '0;
        end else if (strb.ecsl_n && rd_en) begin
            cs_data <= rd_word;
        end
    end

    // A held read cycle must not overlap a store write
    a_no_write_in_hold : assert property (
        @(posedge clk) disable iff (!rst_n)
        !strb.ecsl_n |-> strb.wcstb_n
    ) else $error("control store written while output latch holds");

endmodule

`default_nettype wire

//--- control_store/micro_cache.sv
// Microinstruction cache with write-address register and micro address multiplexer
`timescale 1ns/100ps
`default_nettype none

module micro_cache (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire csctl_pkg::micro_addr_t  addr,        // External micro address
    input  wire                          wca_n,       // Load write-address register
    input  wire csctl_pkg::csctl_strobe_t strb,       // Strobes from the decode
    input  wire csctl_pkg::micro_word_t  cs_data,     // Latched store output
    input  wire csctl_pkg::cache_idx_t   cache_addr,  // Cache read index
    output csctl_pkg::micro_addr_t       ma,          // Effective micro address
    output csctl_pkg::micro_word_t       cache_data   // Cache read word
);

    import csctl_pkg::*;

    micro_addr_t wca_q;                     // Write-address register
    cache_idx_t  wr_idx;                    // Cache entry being filled
    micro_word_t cache_mem [CACHE_DEPTH];

    // Capture the external address while wca_n is low
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wca_q <= '0;
        end else if (!wca_n) begin
            wca_q <= addr;
        end
    end

    // Register drives ma only while ewca_n is low
    assign ma = strb.ewca_n ? addr : wca_q;

    assign wr_idx = ma[CIDX_WIDTH-1:0];     // Low address bits pick the entry

    // Cache fill from the store latch
    always_ff @(posedge clk) begin
        if (!strb.wica_n) begin
            cache_mem[wr_idx] <= cs_data;
        end
    end

    assign cache_data = cache_mem[cache_addr]; // Asynchronous read

endmodule

`default_nettype wire

//--- verilog/csctl_top.sv
// Control-store control top, timer, strobe decode, writable store and microinstruction cache
`timescale 1ns/100ps
`default_nettype none

module csctl_top (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire csctl_pkg::csctl_ctl_t    ctl,         // Mode and fetch inputs
    input  wire csctl_pkg::micro_addr_t   addr,        // External micro address
    input  wire csctl_pkg::micro_word_t   wdata,       // Store write data
    input  wire csctl_pkg::cache_idx_t    cache_addr,  // Cache read index
    output csctl_pkg::cc_code_t           cc,          // Phase code
    output logic                          term_n,      // Last phase marker
    output csctl_pkg::csctl_strobe_t      strb,        // Decoded strobes
    output csctl_pkg::micro_word_t        cs_data,     // Latched microword
    output csctl_pkg::micro_word_t        cache_data   // Cache read word
);

    import csctl_pkg::*;

    micro_addr_t ma;                        // Effective address, cache to store

    cycle_timer u_timer (
        .clk    (clk),
        .rst_n  (rst_n),
        .cc     (cc),
        .term_n (term_n)
    );

    csctl_decode u_decode (
        .clk    (clk),
        .rst_n  (rst_n),
        .ctl    (ctl),
        .cc     (cc),
        .term_n (term_n),
        .strb   (strb)
    );

    control_store u_store (
        .clk     (clk),
        .rst_n   (rst_n),
        .ma      (ma),
        .lua12   (ctl.lua12),
        .wdata   (wdata),
        .strb    (strb),
        .cs_data (cs_data)
    );

    micro_cache u_cache (
        .clk        (clk),
        .rst_n      (rst_n),
        .addr       (addr),
        .wca_n      (ctl.wca_n),
        .strb       (strb),
        .cs_data    (cs_data),
        .cache_addr (cache_addr),
        .ma         (ma),
        .cache_data (cache_data)
    );

endmodule

`default_nettype wire

//--- tb/csctl_tb.sv
// Testbench for the control-store control top, reference model with concurrent checks
`timescale 1ns/100ps
`default_nettype none

module csctl_tb;

    import csctl_pkg::*;

    logic          clk;
    logic          rst_n;
    csctl_ctl_t    ctl;
    micro_addr_t   addr;
    micro_word_t   wdata;
    cache_idx_t    cache_addr;
    cc_code_t      cc;
    logic          term_n;
    csctl_strobe_t strb;
    micro_word_t   cs_data;
    micro_word_t   cache_data;

    int            err_cnt = 0;
    int            to_cnt = 0;
    logic [31:0]   rnd;
    micro_addr_t   wr_addr [8];             // Addresses loaded by the write pass

    // Reference model state
    cc_code_t      m_phase;
    micro_addr_t   m_wca, m_ma;
    micro_word_t   m_cs;
    logic          m_cs_ok;                 // Model knows the latched word
    micro_word_t   m_upp [CS_DEPTH];
    micro_word_t   m_low [CS_DEPTH];
    logic          m_uv [CS_DEPTH];
    logic          m_lv [CS_DEPTH];
    micro_word_t   m_cache [CACHE_DEPTH];
    logic          m_cv [CACHE_DEPTH];
    csctl_strobe_t exp_strb;

    csctl_top csctl_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctl        (ctl),
        .addr       (addr),
        .wdata      (wdata),
        .cache_addr (cache_addr),
        .cc         (cc),
        .term_n     (term_n),
        .strb       (strb),
        .cs_data    (cs_data),
        .cache_data (cache_data)
    );

    always #20 clk = ~clk;                  // 40 ns period

    // Strobes from the phase numbers, true means asserted
    function automatic csctl_strobe_t exp_strobes(input csctl_ctl_t c, input cc_code_t ph);
        logic ws, rw, ld, wc, fm, bk, mid, up, lo;
        csctl_strobe_t s;
        ws  = !c.wcs_n;
        rw  = !c.rwcs_n;
        ld  = !c.lcs_n;
        wc  = !c.wca_n;
        fm  = !c.form_n;
        bk  = !c.brk_n;
        mid = (ph >= 3'd2) && (ph <= 3'd6);  // Phases c to g
        s.wica_n  = !(wc && c.fetch && ph != 3'd7);
        s.wcstb_n = !((ph == 3'd3 && ws && rw) || (ph == 3'd5 && ld));
        s.ecsl_n  = !(rw && !ws && (ph == 3'd2 || (ph >= 3'd4 && ph <= 3'd6)));
        s.ewca_n  = !(rw && ph >= 3'd1 && ph <= 3'd3);
        up = c.lua12 || (wc && c.fetch) || (c.fetch && ph == 3'd0);
        lo = (!c.lua12 && (!c.fetch || ph == 3'd7)) || (mid && fm && !bk)
             || (mid && bk && !c.lua12);
        s.eupp_n  = !up;
        s.elow_n  = !lo;
        return s;
    endfunction

    assign exp_strb = exp_strobes(ctl, m_phase);
    assign m_ma     = exp_strb.ewca_n ? addr : m_wca;

    // Model registers and known flags
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_phase <= '0;
            m_wca   <= '0;
            m_cs    <= '0;
            m_cs_ok <= 1'b1;                // Latch clears on reset
            for (int i = 0; i < CS_DEPTH; i++) begin
                m_uv[i] <= 1'b0;
                m_lv[i] <= 1'b0;
            end
            for (int i = 0; i < CACHE_DEPTH; i++) begin
                m_cv[i] <= 1'b0;
            end
        end else begin
            m_phase <= m_phase + 3'd1;      // Wraps from h to a
            if (!ctl.wca_n) m_wca <= addr;
            if (!exp_strb.wcstb_n && ctl.lua12) m_uv[m_ma] <= 1'b1;
            if (!exp_strb.wcstb_n && !ctl.lua12) m_lv[m_ma] <= 1'b1;
            if (exp_strb.ecsl_n && !exp_strb.eupp_n) begin
                m_cs    <= m_upp[m_ma];
                m_cs_ok <= m_uv[m_ma];
            end else if (exp_strb.ecsl_n && !exp_strb.elow_n) begin
                m_cs    <= m_low[m_ma];
                m_cs_ok <= m_lv[m_ma];
            end
            if (!exp_strb.wica_n) m_cv[m_ma[CIDX_WIDTH-1:0]] <= m_cs_ok;
        end
    end

    // Model memory contents
    always_ff @(posedge clk) begin
        if (!exp_strb.wcstb_n && ctl.lua12) m_upp[m_ma] <= wdata;
        if (!exp_strb.wcstb_n && !ctl.lua12) m_low[m_ma] <= wdata;
        if (!exp_strb.wica_n) m_cache[m_ma[CIDX_WIDTH-1:0]] <= m_cs;
    end

    a_phase : assert property (@(posedge clk) disable iff (!rst_n) cc == m_phase)
        else begin
            err_cnt++;
            $display("Error: cc got %h expected %h", $sampled(cc), $sampled(m_phase));
        end

    a_term : assert property (@(posedge clk) disable iff (!rst_n) term_n == (m_phase != 3'd7))
        else begin
            err_cnt++;
            $display("Error: term_n got %h in phase %h", $sampled(term_n), $sampled(m_phase));
        end

    a_strb : assert property (@(posedge clk) disable iff (!rst_n) strb == exp_strb)
        else begin
            err_cnt++;
            $display("Error: strb got %h expected %h", $sampled(strb), $sampled(exp_strb));
        end

    // Write strobes stay off with the modes idle
    a_idle : assert property (@(posedge clk) disable iff (!rst_n)
        (ctl.lcs_n && ctl.wcs_n && ctl.wca_n) |-> (strb.wcstb_n && strb.wica_n))
        else begin
            err_cnt++;
            $display("Error: write strobe active with idle modes, strb %h", $sampled(strb));
        end

    a_cs : assert property (@(posedge clk) disable iff (!rst_n) m_cs_ok |-> cs_data == m_cs)
        else begin
            err_cnt++;
            $display("Error: cs_data got %h expected %h", $sampled(cs_data), $sampled(m_cs));
        end

    a_hold : assert property (@(posedge clk) disable iff (!rst_n)
        !strb.ecsl_n |=> $stable(cs_data))
        else begin
            err_cnt++;
            $display("Error: cs_data moved from %h to %h in hold", $past(cs_data),
                     $sampled(cs_data));
        end

    a_cache : assert property (@(posedge clk) disable iff (!rst_n)
        m_cv[cache_addr] |-> cache_data == m_cache[cache_addr])
        else begin
            err_cnt++;
            $display("Error: cache_data got %h expected %h", $sampled(cache_data),
                     $sampled(m_cache[cache_addr]));
        end

    task automatic tick();
        @(posedge clk);
        #2;                                 // Drive just after the edge
    endtask

    task automatic set_idle();
        ctl = '{form_n: 1'b1, lcs_n: 1'b1, rwcs_n: 1'b1, wcs_n: 1'b1,
                brk_n: 1'b1, wca_n: 1'b1, fetch: 1'b0, lua12: 1'b0};
    endtask

    // Bounded wait for a given phase
    task automatic wait_phase(input cc_code_t ph);
        int n;
        n = 0;
        while (cc != ph && n < 16) begin
            tick();
            n++;
        end
        if (cc != ph) begin
            to_cnt++;
            $display("Timed out waiting for phase %0d", ph);
        end
    endtask

    // Load control write in phase f
    task automatic load_word(input logic upper, input micro_addr_t a, input micro_word_t d);
        wait_phase(3'd5);
        ctl.lcs_n = 1'b0;
        ctl.lua12 = upper;
        addr      = a;
        wdata     = d;
        tick();
        set_idle();
    endtask

    task automatic read_word(input logic upper, input micro_addr_t a);
        set_idle();
        ctl.lua12 = upper;                  // Selects eupp_n or elow_n
        addr      = a;
        tick();
        tick();
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        rnd        = $urandom(32'h586e);
        addr       = '0;
        wdata      = '0;
        cache_addr = '0;
        set_idle();
        repeat (16) @(posedge clk);
        #2 rst_n = 1'b1;
        repeat (12) tick();                 // Phase wrap and idle strobes
        for (int k = 0; k < 8; k++) begin
            rnd = $urandom();
            wr_addr[k] = rnd[7:0];
            load_word(1'b0, wr_addr[k], $urandom());
            load_word(1'b1, wr_addr[k], $urandom());
        end
        for (int k = 0; k < 8; k++) begin
            read_word(1'b0, wr_addr[k]);
            read_word(1'b1, wr_addr[k]);
        end
        ctl.rwcs_n = 1'b0;                  // Read cycle, latch holds in c and e to g
        for (int k = 0; k < 16; k++) begin
            addr = wr_addr[k % 8];
            tick();
        end
        for (int k = 0; k < 8; k++) begin
            read_word(1'b0, wr_addr[k]);
            ctl.fetch = 1'b1;               // Fill the cache from the latch
            ctl.wca_n = 1'b0;
            tick();
            set_idle();
            cache_addr = wr_addr[k][CIDX_WIDTH-1:0];
            tick();
            tick();
        end
        for (int k = 0; k < 600; k++) begin
            rnd        = $urandom();
            ctl        = rnd[7:0];
            addr       = rnd[15:8];
            cache_addr = rnd[19:16];
            wdata      = $urandom();
            if (!ctl.lcs_n && !ctl.rwcs_n && ctl.wcs_n) ctl.lcs_n = 1'b1; // No write in hold
            tick();
        end
        set_idle();
        repeat (4) tick();
        $display("Checks done with %0d errors and %0d timeouts", err_cnt, to_cnt);
        if (err_cnt == 0 && to_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
common/csctl_pkg.sv
verilog/cycle_timer.sv
csctl/csctl_decode.sv
control_store/control_store.sv
control_store/micro_cache.sv
verilog/csctl_top.sv
tb/csctl_tb.sv

//--- run.sh
#!/bin/sh
# Compile and run the control-store testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module csctl_tb -f project.f -o csctl_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/csctl_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "CHECKS FAILED" sim.log; then
    exit 1
fi
exit 0
